// ==== source/eth_buffer_params.svh ====
// Width and depth constants for the Ethernet frame buffer
`ifndef ETH_BUFFER_PARAMS_SVH
`define ETH_BUFFER_PARAMS_SVH

// Stream beat layout
`define ETH_DATA_WIDTH 64
`define ETH_KEEP_WIDTH 8

// Frame FIFO depths in beats, powers of two
`define ETH_TX_FIFO_DEPTH 32
`define ETH_RX_FIFO_DEPTH 32

// RX timestamp queue entries
`define ETH_TS_QUEUE_DEPTH 8

// PTP field widths
`define ETH_TS_WIDTH 96
`define ETH_TAG_WIDTH 16

`endif

// ==== source/eth_stream_pkg.sv ====
// Stream beat, FIFO status and FIFO write-state types
`include "eth_buffer_params.svh"

package eth_stream_pkg;

    // One beat of the frame stream
    typedef struct packed {
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic [`ETH_KEEP_WIDTH-1:0] keep;
        logic                       last;
    } stream_beat_t;

    // Single-cycle event pulses from a frame FIFO
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

    // Write side of the frame FIFO
    typedef enum logic [1:0] {
        idle,
        storing,
        dropping
    } fifo_state_e;

endpackage

// ==== source/eth_ptp_pkg.sv ====
// PTP frame tag and timestamp types
`include "eth_buffer_params.svh"

package eth_ptp_pkg;

    // Tag carried alongside each TX frame
    typedef logic [`ETH_TAG_WIDTH-1:0] ptp_tag_t;

    // 96-bit timestamp, seconds then nanoseconds then fraction
    typedef struct packed {
        logic [47:0]                sec;
        logic [31:0]                ns;
        // Remaining low bits hold fractional nanoseconds
        logic [`ETH_TS_WIDTH-81:0]  fns;
    } ptp_ts_t;

endpackage

// ==== source/frame_fifo.sv ====
// Store-and-forward frame FIFO with bad-frame drop and optional drop when full
`timescale 1ns/1ps

module frame_fifo #(
    // Must be a power of two
    parameter int  DEPTH          = 32,
    parameter bit  DROP_WHEN_FULL = 1'b0,
    parameter type user_t         = logic
) (
    input  logic                         logic_clk,
    input  logic                         logic_rst,

    input  eth_stream_pkg::stream_beat_t in_beat,
    input  user_t                        in_user,
    input  logic                         in_bad,
    input  logic                         in_valid,
    output logic                         in_ready,

    output eth_stream_pkg::stream_beat_t out_beat,
    output user_t                        out_user,
    output logic                         out_valid,
    input  logic                         out_ready,

    output eth_stream_pkg::fifo_status_t status
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    eth_stream_pkg::stream_beat_t mem_beat [DEPTH];
    user_t                        mem_user [DEPTH];

    // Extra top bit tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] commit_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    eth_stream_pkg::fifo_state_e state;

    logic run;
    logic full;
    logic committed_empty;
    logic accept;
    logic store;
    logic load;

    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    assign committed_empty = (rd_ptr == commit_ptr);

    // In drop mode the input never stalls, a beat that does not fit cuts the frame
    assign in_ready = run && (DROP_WHEN_FULL || !full);
    assign accept   = in_valid && in_ready;
    assign store    = accept && (state != eth_stream_pkg::dropping) && !full;

    // Output register refills whenever it is empty or being taken
    assign load = !committed_empty && (!out_valid || out_ready);

    // Write side FSM, commit and rollback
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            run        <= 1'b0;
            state      <= eth_stream_pkg::idle;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            status     <= '0;
        end else begin
            run    <= 1'b1;
            status <= '0;
            if (accept) begin
                if (state == eth_stream_pkg::dropping) begin
                    // Swallow the rest of a cut frame
                    if (in_beat.last) begin
                        status.overflow <= 1'b1;
                        state           <= eth_stream_pkg::idle;
                    end
                end else if (full) begin
                    // No room, discard the partial frame
                    wr_ptr <= commit_ptr;
                    if (in_beat.last) begin
                        status.overflow <= 1'b1;
                        state           <= eth_stream_pkg::idle;
                    end else begin
                        state <= eth_stream_pkg::dropping;
                    end
                end else if (in_beat.last) begin
                    state <= eth_stream_pkg::idle;
                    if (in_bad) begin
                        wr_ptr           <= commit_ptr;
                        status.bad_frame <= 1'b1;
                    end else begin
                        wr_ptr            <= wr_ptr + 1'b1;
                        commit_ptr        <= wr_ptr + 1'b1;
                        status.good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    state  <= eth_stream_pkg::storing;
                end
            end
        end
    end

    // Read side control
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else if (load) begin
            rd_ptr    <= rd_ptr + 1'b1;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Storage and output stage payload
    always_ff @(posedge logic_clk) begin
        if (store) begin
            mem_beat[wr_ptr[ADDR_WIDTH-1:0]] <= in_beat;
            mem_user[wr_ptr[ADDR_WIDTH-1:0]] <= in_user;
        end
        if (load) begin
            out_beat <= mem_beat[rd_ptr[ADDR_WIDTH-1:0]];
            out_user <= mem_user[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

endmodule

// ==== source/rx_ts_extract.sv ====
// First-beat timestamp capture and timestamp queue for the RX output
`timescale 1ns/1ps
`include "eth_buffer_params.svh"

module rx_ts_extract (
    input  logic                 logic_clk,
    input  logic                 logic_rst,

    input  logic                 beat_valid,
    input  logic                 beat_ready,
    input  logic                 beat_last,
    input  eth_ptp_pkg::ptp_ts_t beat_ts,

    output eth_ptp_pkg::ptp_ts_t ts,
    output logic                 ts_valid,
    input  logic                 ts_ready
);

    localparam int QUEUE_DEPTH = `ETH_TS_QUEUE_DEPTH;
    localparam int ADDR_WIDTH  = $clog2(QUEUE_DEPTH);

    eth_ptp_pkg::ptp_ts_t queue_mem [QUEUE_DEPTH];

    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic first_beat;
    logic take;
    logic queue_full;
    logic push;
    logic pop;

    assign take = beat_valid && beat_ready;

    assign queue_full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                        (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    // Timestamp is lost when the queue has no room
    assign push = take && first_beat && !queue_full;

    assign ts_valid = (wr_ptr != rd_ptr);
    assign ts       = queue_mem[rd_ptr[ADDR_WIDTH-1:0]];
    assign pop      = ts_valid && ts_ready;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            first_beat <= 1'b1;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else begin
            // Next beat after a last beat opens a new frame
            if (take) begin
                first_beat <= beat_last;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (push) begin
            queue_mem[wr_ptr[ADDR_WIDTH-1:0]] <= beat_ts;
        end
    end

endmodule

// ==== source/eth_fifo_top.sv ====
// Top level with TX frame FIFO, RX frame FIFO and RX timestamp extractor
`timescale 1ns/1ps
`include "eth_buffer_params.svh"

module eth_fifo_top (
    input  logic                         logic_clk,
    input  logic                         logic_rst,

    // TX input
    input  eth_stream_pkg::stream_beat_t tx_in,
    input  eth_ptp_pkg::ptp_tag_t        tx_in_tag,
    input  logic                         tx_in_bad,
    input  logic                         tx_in_valid,
    output logic                         tx_in_ready,

    // TX output
    output eth_stream_pkg::stream_beat_t tx_out,
    output eth_ptp_pkg::ptp_tag_t        tx_out_tag,
    output logic                         tx_out_valid,
    input  logic                         tx_out_ready,

    // RX input, no back-pressure toward the line
    input  eth_stream_pkg::stream_beat_t rx_in,
    input  eth_ptp_pkg::ptp_ts_t         rx_in_ts,
    input  logic                         rx_in_bad,
    input  logic                         rx_in_valid,

    // RX output
    output eth_stream_pkg::stream_beat_t rx_out,
    output logic                         rx_out_valid,
    input  logic                         rx_out_ready,

    // RX timestamps, one per delivered frame
    output eth_ptp_pkg::ptp_ts_t         rx_ts,
    output logic                         rx_ts_valid,
    input  logic                         rx_ts_ready,

    output eth_stream_pkg::fifo_status_t tx_status,
    output eth_stream_pkg::fifo_status_t rx_status
);

    // Timestamp stored with the beat now on the RX output
    eth_ptp_pkg::ptp_ts_t rx_out_ts;

    frame_fifo #(
        .DEPTH          (`ETH_TX_FIFO_DEPTH),
        .DROP_WHEN_FULL (1'b0),
        .user_t         (eth_ptp_pkg::ptp_tag_t)
    ) i_tx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (tx_in),
        .in_user   (tx_in_tag),
        .in_bad    (tx_in_bad),
        .in_valid  (tx_in_valid),
        .in_ready  (tx_in_ready),
        .out_beat  (tx_out),
        .out_user  (tx_out_tag),
        .out_valid (tx_out_valid),
        .out_ready (tx_out_ready),
        .status    (tx_status)
    );

    frame_fifo #(
        .DEPTH          (`ETH_RX_FIFO_DEPTH),
        .DROP_WHEN_FULL (1'b1),
        .user_t         (eth_ptp_pkg::ptp_ts_t)
    ) i_rx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (rx_in),
        .in_user   (rx_in_ts),
        .in_bad    (rx_in_bad),
        .in_valid  (rx_in_valid),
        .in_ready  (),
        .out_beat  (rx_out),
        .out_user  (rx_out_ts),
        .out_valid (rx_out_valid),
        .out_ready (rx_out_ready),
        .status    (rx_status)
    );

    rx_ts_extract i_rx_ts (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .beat_valid (rx_out_valid),
        .beat_ready (rx_out_ready),
        .beat_last  (rx_out.last),
        .beat_ts    (rx_out_ts),
        .ts         (rx_ts),
        .ts_valid   (rx_ts_valid),
        .ts_ready   (rx_ts_ready)
    );

endmodule

// ==== verification/eth_fifo_chk.sv ====
// Bound assertions for output handshakes and FIFO status pulses
`timescale 1ns/1ps

module eth_fifo_chk (
    input logic                         logic_clk,
    input logic                         logic_rst,
    input eth_stream_pkg::stream_beat_t tx_out,
    input eth_ptp_pkg::ptp_tag_t        tx_out_tag,
    input logic                         tx_out_valid,
    input logic                         tx_out_ready,
    input eth_stream_pkg::stream_beat_t rx_out,
    input logic                         rx_out_valid,
    input logic                         rx_out_ready,
    input eth_ptp_pkg::ptp_ts_t         rx_ts,
    input logic                         rx_ts_valid,
    input logic                         rx_ts_ready,
    input eth_stream_pkg::fifo_status_t tx_status,
    input eth_stream_pkg::fifo_status_t rx_status
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Stalled outputs keep valid and contents
    a_tx_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        tx_out_valid && !tx_out_ready |=> tx_out_valid && $stable(tx_out) && $stable(tx_out_tag))
    else begin
        $error("TX output changed while stalled");
        fail_count++;
    end

    a_rx_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_out_valid && !rx_out_ready |=> rx_out_valid && $stable(rx_out))
    else begin
        $error("RX output changed while stalled");
        fail_count++;
    end

    a_ts_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_ts_valid && !rx_ts_ready |=> rx_ts_valid && $stable(rx_ts))
    else begin
        $error("RX timestamp changed while stalled");
        fail_count++;
    end

    // Frames are at least two cycles apart, so pulses never follow each other
    a_tx_pulse: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (|tx_status) |=> !(|tx_status))
    else begin
        $error("TX status pulse longer than one cycle");
        fail_count++;
    end

    a_rx_pulse: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (|rx_status) |=> !(|rx_status))
    else begin
        $error("RX status pulse longer than one cycle");
        fail_count++;
    end

    a_one_event: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0(tx_status) && $onehot0(rx_status))
    else begin
        $error("More than one status bit set in a cycle");
        fail_count++;
    end

endmodule

bind eth_fifo_top eth_fifo_chk i_chk (.*);

// ==== verification/eth_fifo_tb.sv ====
// Testbench with stimulus, reference model and compare process for the frame buffer
`timescale 1ns/1ps
`include "eth_buffer_params.svh"

module eth_fifo_tb;

    localparam int TIMEOUT = 2000;

    logic                         logic_clk;
    logic                         logic_rst;
    eth_stream_pkg::stream_beat_t tx_in;
    eth_ptp_pkg::ptp_tag_t        tx_in_tag;
    logic                         tx_in_bad;
    logic                         tx_in_valid;
    logic                         tx_in_ready;
    eth_stream_pkg::stream_beat_t tx_out;
    eth_ptp_pkg::ptp_tag_t        tx_out_tag;
    logic                         tx_out_valid;
    logic                         tx_out_ready;
    eth_stream_pkg::stream_beat_t rx_in;
    eth_ptp_pkg::ptp_ts_t         rx_in_ts;
    logic                         rx_in_bad;
    logic                         rx_in_valid;
    eth_stream_pkg::stream_beat_t rx_out;
    logic                         rx_out_valid;
    logic                         rx_out_ready;
    eth_ptp_pkg::ptp_ts_t         rx_ts;
    logic                         rx_ts_valid;
    logic                         rx_ts_ready;
    eth_stream_pkg::fifo_status_t tx_status;
    eth_stream_pkg::fifo_status_t rx_status;

    // Expected output streams
    eth_stream_pkg::stream_beat_t tx_exp_q[$];
    eth_ptp_pkg::ptp_tag_t        tag_exp_q[$];
    eth_stream_pkg::stream_beat_t rx_exp_q[$];
    eth_ptp_pkg::ptp_ts_t         ts_exp_q[$];

    // Pulse counts in status bit order of good, bad and overflow
    int seen_tx[3];
    int seen_rx[3];
    int exp_tx[3];
    int exp_rx[3];

    int errors;
    int checks;
    int test_errors;
    bit tx_hold;
    bit rx_hold;

    initial logic_clk = 1'b0;
    always #4 logic_clk = ~logic_clk;

    eth_fifo_top i_dut (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .tx_in        (tx_in),
        .tx_in_tag    (tx_in_tag),
        .tx_in_bad    (tx_in_bad),
        .tx_in_valid  (tx_in_valid),
        .tx_in_ready  (tx_in_ready),
        .tx_out       (tx_out),
        .tx_out_tag   (tx_out_tag),
        .tx_out_valid (tx_out_valid),
        .tx_out_ready (tx_out_ready),
        .rx_in        (rx_in),
        .rx_in_ts     (rx_in_ts),
        .rx_in_bad    (rx_in_bad),
        .rx_in_valid  (rx_in_valid),
        .rx_out       (rx_out),
        .rx_out_valid (rx_out_valid),
        .rx_out_ready (rx_out_ready),
        .rx_ts        (rx_ts),
        .rx_ts_valid  (rx_ts_valid),
        .rx_ts_ready  (rx_ts_ready),
        .tx_status    (tx_status),
        .rx_status    (rx_status)
    );

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Bad frames vanish, and so do RX frames longer than the tracked free space
    function automatic bit frame_kept(input bit bad, input int len, input bit rx_path,
                                      input int free_beats);
        return !bad && (!rx_path || len <= free_beats);
    endfunction

    function automatic eth_stream_pkg::stream_beat_t make_beat(input bit last);
        eth_stream_pkg::stream_beat_t beat;
        beat.data = {$urandom, $urandom};
        // Only the last beat may have short contiguous byte enables
        beat.keep = last ? 8'hff >> $urandom_range(0, 7) : 8'hff;
        beat.last = last;
        return beat;
    endfunction

    task automatic send_tx_frame(input int len, input bit bad);
        eth_stream_pkg::stream_beat_t beat;
        eth_ptp_pkg::ptp_tag_t        tag;
        bit                           kept;
        int                           waited;
        int                           i;
        tag  = 16'($urandom);
        kept = frame_kept(bad, len, 1'b0, 0);
        if (kept)
            exp_tx[0]++;
        else
            exp_tx[1]++;
        for (i = 0; i < len; i++) begin
            beat = make_beat(i == len - 1);
            if (kept) begin
                tx_exp_q.push_back(beat);
                tag_exp_q.push_back(tag);
            end
            @(negedge logic_clk);
            tx_in       = beat;
            tx_in_tag   = tag;
            tx_in_bad   = bad;
            tx_in_valid = 1'b1;
            waited      = 0;
            while (!tx_in_ready && waited < TIMEOUT) begin
                @(negedge logic_clk);
                waited++;
            end
            if (!tx_in_ready) begin
                $display("TX input stayed stalled too long, beat %0d not accepted", i);
                errors++;
            end
        end
        @(negedge logic_clk);
        tx_in_valid = 1'b0;
    endtask

    task automatic send_rx_frame(input int len, input bit bad, input bit wait_room);
        eth_stream_pkg::stream_beat_t beat;
        eth_ptp_pkg::ptp_ts_t         ts;
        bit                           kept;
        int                           waited;
        int                           free_beats;
        int                           i;
        ts.sec = {16'($urandom), $urandom};
        ts.ns  = $urandom;
        ts.fns = 16'($urandom);
        waited = 0;
        while (wait_room && rx_exp_q.size() + len > `ETH_RX_FIFO_DEPTH && waited < TIMEOUT) begin
            @(negedge logic_clk);
            waited++;
        end
        if (waited == TIMEOUT) begin
            $display("RX FIFO never had room for a %0d beat frame", len);
            errors++;
        end
        free_beats = `ETH_RX_FIFO_DEPTH - rx_exp_q.size();
        kept       = frame_kept(bad, len, 1'b1, free_beats);
        if (kept) begin
            exp_rx[0]++;
            ts_exp_q.push_back(ts);
        end else if (len > free_beats) begin
            exp_rx[2]++;
        end else begin
            exp_rx[1]++;
        end
        for (i = 0; i < len; i++) begin
            beat = make_beat(i == len - 1);
            if (kept)
                rx_exp_q.push_back(beat);
            @(negedge logic_clk);
            rx_in       = beat;
            rx_in_ts    = ts;
            rx_in_bad   = bad;
            rx_in_valid = 1'b1;
            // Later beats carry later times so only the first one may come out
            ts.ns = ts.ns + 32'd1;
        end
        @(negedge logic_clk);
        rx_in_valid = 1'b0;
    endtask

    // Compare process that also drives the output readies
    always @(negedge logic_clk) begin
        int j;
        tx_out_ready = !tx_hold && ($urandom_range(0, 3) != 0);
        rx_out_ready = !rx_hold && ($urandom_range(0, 3) != 0);
        rx_ts_ready  = ($urandom_range(0, 3) != 0);
        for (j = 0; j < 3; j++) begin
            seen_tx[j] += int'(tx_status[j]);
            seen_rx[j] += int'(rx_status[j]);
        end
        if (tx_out_valid && tx_out_ready) begin
            if (tx_exp_q.size() == 0) begin
                $display("Beat on the TX output that no sent frame accounts for");
                errors++;
            end else begin
                check_value("tx_out", tx_exp_q.pop_front(), tx_out);
                check_value("tx_out_tag", tag_exp_q.pop_front(), tx_out_tag);
            end
        end
        if (rx_out_valid && rx_out_ready) begin
            if (rx_exp_q.size() == 0) begin
                $display("Beat on the RX output that no sent frame accounts for");
                errors++;
            end else begin
                check_value("rx_out", rx_exp_q.pop_front(), rx_out);
            end
        end
        if (rx_ts_valid && rx_ts_ready) begin
            if (ts_exp_q.size() == 0) begin
                $display("Timestamp on rx_ts that no delivered frame accounts for");
                errors++;
            end else begin
                check_value("rx_ts", ts_exp_q.pop_front(), rx_ts);
            end
        end
    end

    function automatic bit outputs_pending();
        bit pending;
        int j;
        pending = tx_exp_q.size() != 0 || rx_exp_q.size() != 0 || ts_exp_q.size() != 0;
        for (j = 0; j < 3; j++)
            pending = pending || seen_tx[j] < exp_tx[j] || seen_rx[j] < exp_rx[j];
        return pending;
    endfunction

    task automatic finish_test(input int num, input string name);
        int waited;
        int j;
        waited = 0;
        while (outputs_pending() && waited < TIMEOUT) begin
            @(negedge logic_clk);
            waited++;
        end
        if (outputs_pending()) begin
            $display("Outputs or status pulses still missing at the end of test %0d", num);
            errors++;
        end
        for (j = 0; j < 3; j++) begin
            check_value($sformatf("tx_status[%0d] pulses", j), exp_tx[j], seen_tx[j]);
            check_value($sformatf("rx_status[%0d] pulses", j), exp_rx[j], seen_rx[j]);
        end
        $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic wait_tx_full();
        int waited;
        waited = 0;
        while (tx_in_ready && waited < TIMEOUT) begin
            @(negedge logic_clk);
            waited++;
        end
        if (tx_in_ready) begin
            $display("TX input ready never dropped with the output held");
            errors++;
        end
    endtask

    initial begin
        int i;
        void'($urandom(32'hc992));
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        tx_hold      = 1'b0;
        rx_hold      = 1'b0;
        tx_in        = '0;
        tx_in_tag    = '0;
        tx_in_bad    = 1'b0;
        tx_in_valid  = 1'b0;
        tx_out_ready = 1'b0;
        rx_in        = '0;
        rx_in_ts     = '0;
        rx_in_bad    = 1'b0;
        rx_in_valid  = 1'b0;
        rx_out_ready = 1'b0;
        rx_ts_ready  = 1'b0;
        logic_rst    = 1'b1;
        repeat (5) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;

        for (i = 0; i < 10; i++)
            send_tx_frame($urandom_range(1, 12), 1'b0);
        finish_test(1, "tx good frames");

        // Every third frame bad
        for (i = 0; i < 12; i++)
            send_tx_frame($urandom_range(1, 12), i % 3 == 1);
        finish_test(2, "tx bad frames");

        // Output held until the input side stalls
        @(posedge logic_clk);
        tx_hold = 1'b1;
        fork
            repeat (5) send_tx_frame(8, 1'b0);
            begin
                wait_tx_full();
                @(posedge logic_clk);
                tx_hold = 1'b0;
            end
        join
        finish_test(3, "tx back-pressure");

        for (i = 0; i < 16; i++)
            send_rx_frame($urandom_range(1, 12), i % 5 == 3, 1'b1);
        finish_test(4, "rx timestamps");

        // Three frames fill the held FIFO and the fourth cannot fit
        @(posedge logic_clk);
        rx_hold = 1'b1;
        repeat (3) send_rx_frame(10, 1'b0, 1'b1);
        send_rx_frame(12, 1'b0, 1'b0);
        check_value("rx_out_valid", 1'b1, rx_out_valid);
        @(posedge logic_clk);
        rx_hold = 1'b0;
        finish_test(5, "rx drop when full");

        errors = errors + i_dut.i_chk.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/eth_stream_pkg.sv
source/eth_ptp_pkg.sv
source/frame_fifo.sv
source/rx_ts_extract.sv
source/eth_fifo_top.sv
verification/eth_fifo_chk.sv
verification/eth_fifo_tb.sv

// ==== Makefile ====
# Verilator build and run for the Ethernet frame buffer testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = eth_fifo_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
SIM_ARGS = +verilator+error+limit+1000
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
